// ==== src/vldu_pkg.sv ====
`default_nettype none

package vldu_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int NrLanes          = 4;
  localparam int LaneBytes        = 8;
  localparam int WordBytes        = NrLanes * LaneBytes;
  localparam int NrVInsn          = 8;
  localparam int InsnQueueDepth   = 4;
  localparam int ResultQueueDepth = 2;
  localparam int MaxVlBytes       = 256;
  localparam int RegWords         = MaxVlBytes / WordBytes;

  // Derived index widths
  localparam int WordByteBits = $clog2(WordBytes);
  localparam int WordIdxBits  = $clog2(RegWords);
  localparam int IqPtrBits    = $clog2(InsnQueueDepth);
  localparam int IqCntBits    = IqPtrBits + 1;
  localparam int RqPtrBits    = $clog2(ResultQueueDepth);
  localparam int RqCntBits    = RqPtrBits + 1;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [2:0]  vid_t;
  typedef logic [4:0]  vreg_t;
  typedef logic [8:0]  vlen_t;
  typedef logic [7:0]  vaddr_t;
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;

  // Useful bytes carried by one read beat
  localparam int BeatBytes = $bits(elen_t) / 8;

  // Value is log2 of the element width in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Load instruction, vl counted in elements
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vew_e  vsew;
    vlen_t vl;
  } vinsn_t;

  // One lane's share of a register-file word
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_payload_t;

  ////////////////////
  // Functions
  ////////////////////

  // Byte length of an instruction
  function automatic vlen_t vinsn_bytes(input vinsn_t insn);
    return vlen_t'(insn.vl << insn.vsew);
  endfunction

  // Word byte b -> lane * LaneBytes + byte offset inside that lane
  function automatic logic [WordByteBits-1:0] shuffle_byte(input logic [WordByteBits-1:0] b,
                                                           input vew_e ew);
    int unsigned elem;
    int unsigned k;
    int unsigned lane;
    int unsigned offset;
    elem   = b >> int'(ew);
    k      = b & ((1 << int'(ew)) - 1);
    lane   = elem % NrLanes;
    // Element row inside the lane, scaled back to bytes
    offset = ((elem / NrLanes) << int'(ew)) + k;
    return WordByteBits'(lane * LaneBytes + offset);
  endfunction

  // Lane word address of word w of register vd
  function automatic vaddr_t word_addr(input vreg_t vd, input logic [WordIdxBits-1:0] w);
    return vaddr_t'(int'(vd) * RegWords + int'(w));
  endfunction

endpackage

`default_nettype wire

// ==== src/vldu_insn_queue.sv ====
`default_nettype none

module vldu_insn_queue import vldu_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Accept side
  input  logic               acc_valid_i,
  input  vinsn_t             acc_insn_i,
  output logic               acc_ready_o,
  // Issue side, towards the packer
  output logic               issue_valid_o,
  output vinsn_t             issue_insn_o,
  input  logic               issue_done_i,
  // Commit side
  input  logic               word_retired_i,
  output logic [NrVInsn-1:0] vinsn_done_o,
  output logic               load_complete_o
);

  ////////////////////
  // Queue state
  ////////////////////

  // Instruction storage
  vinsn_t mem_q [InsnQueueDepth];

  // Accept, issue and commit pointers
  logic [IqPtrBits-1:0] accept_pnt_q, accept_pnt_d;
  logic [IqPtrBits-1:0] issue_pnt_q, issue_pnt_d;
  logic [IqPtrBits-1:0] commit_pnt_q, commit_pnt_d;

  // Instructions waiting for issue and for commit
  logic [IqCntBits-1:0] issue_cnt_q, issue_cnt_d;
  logic [IqCntBits-1:0] commit_cnt_q, commit_cnt_d;

  // IDs in flight inside this unit
  logic [NrVInsn-1:0] running_q, running_d;

  // Bytes of the commit entry not yet retired
  vlen_t commit_bytes_q, commit_bytes_d;

  logic [NrVInsn-1:0] done_d;
  logic               complete_d;

  logic   full;
  logic   acc_fire;
  logic   commit_valid;
  vinsn_t commit_insn;

  assign full = (commit_cnt_q == IqCntBits'(InsnQueueDepth));

  // Refuse an ID until its previous instance is done
  assign acc_ready_o = !full && !running_q[acc_insn_i.id];
  assign acc_fire    = acc_valid_i && acc_ready_o;

  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_insn_o  = mem_q[issue_pnt_q];

  assign commit_valid = (commit_cnt_q != '0);
  assign commit_insn  = mem_q[commit_pnt_q];

  always_comb begin
    accept_pnt_d   = accept_pnt_q;
    issue_pnt_d    = issue_pnt_q;
    commit_pnt_d   = commit_pnt_q;
    issue_cnt_d    = issue_cnt_q;
    commit_cnt_d   = commit_cnt_q;
    running_d      = running_q;
    commit_bytes_d = commit_bytes_q;
    done_d         = '0;
    complete_d     = 1'b0;

    // Last beat of the issue entry taken
    if (issue_done_i) begin
      issue_pnt_d = issue_pnt_q + 1'b1;
      issue_cnt_d = issue_cnt_q - 1'b1;
    end

    // Count down one word per retire and floor at zero
    if (word_retired_i) begin
      if (commit_bytes_q > vlen_t'(WordBytes))
        commit_bytes_d = commit_bytes_q - vlen_t'(WordBytes);
      else
        commit_bytes_d = '0;
    end

    // Commit entry fully written
    if (commit_valid && commit_bytes_d == '0) begin
      done_d[commit_insn.id]    = 1'b1;
      complete_d                = 1'b1;
      running_d[commit_insn.id] = 1'b0;
      commit_pnt_d              = commit_pnt_q + 1'b1;
      commit_cnt_d              = commit_cnt_q - 1'b1;
      // Next entry becomes the commit entry when there is one
      if (commit_cnt_d != '0)
        commit_bytes_d = vinsn_bytes(mem_q[commit_pnt_d]);
    end

    // New instruction
    if (acc_fire) begin
      running_d[acc_insn_i.id] = 1'b1;
      accept_pnt_d             = accept_pnt_q + 1'b1;
      issue_cnt_d              = issue_cnt_d + 1'b1;
      // This one commits first when the queue is empty
      if (commit_cnt_d == '0)
        commit_bytes_d = vinsn_bytes(acc_insn_i);
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q    <= '0;
      issue_pnt_q     <= '0;
      commit_pnt_q    <= '0;
      issue_cnt_q     <= '0;
      commit_cnt_q    <= '0;
      running_q       <= '0;
      commit_bytes_q  <= '0;
      vinsn_done_o    <= '0;
      load_complete_o <= 1'b0;
    end else begin
      accept_pnt_q    <= accept_pnt_d;
      issue_pnt_q     <= issue_pnt_d;
      commit_pnt_q    <= commit_pnt_d;
      issue_cnt_q     <= issue_cnt_d;
      commit_cnt_q    <= commit_cnt_d;
      running_q       <= running_d;
      commit_bytes_q  <= commit_bytes_d;
      // Done pulses show one cycle after the last retire
      vinsn_done_o    <= done_d;
      load_complete_o <= complete_d;
    end
  end

  // Storage written at the accept pointer
  always_ff @(posedge clk_i) begin
    if (acc_fire)
      mem_q[accept_pnt_q] <= acc_insn_i;
  end

  // Pending entries never exceed the queue and issue never trails behind commit
  a_acc_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (commit_cnt_q <= IqCntBits'(InsnQueueDepth)) && (issue_cnt_q <= commit_cnt_q));

  // The packer only finishes an instruction that was issued
  a_done_needs_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> issue_valid_o);

endmodule

`default_nettype wire

// ==== src/vldu_beat_packer.sv ====
`default_nettype none

module vldu_beat_packer import vldu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Instruction being issued
  input  logic                        issue_valid_i,
  input  vinsn_t                      issue_insn_i,
  output logic                        issue_done_o,
  // Read beats from memory
  input  logic                        r_valid_i,
  input  elen_t                       r_data_i,
  output logic                        r_ready_o,
  // Word push into the result queue
  output logic                        push_o,
  output lane_payload_t [NrLanes-1:0] push_word_o,
  input  logic                        rq_full_i
);

  ////////////////////
  // Packer state
  ////////////////////

  // Remaining issue bytes
  // Zero while no instruction has started
  vlen_t issue_bytes_q, issue_bytes_d;
  vlen_t remaining;

  // Byte pointer inside the word under assembly
  logic [WordByteBits-1:0] word_pnt_q, word_pnt_d;

  // Word index inside the destination register
  logic [WordIdxBits-1:0] word_idx_q, word_idx_d;

  // Word under assembly
  // Only its data and enables are used
  lane_payload_t [NrLanes-1:0] word_q, word_d;

  // Shuffled destination of each beat byte
  logic [WordByteBits-1:0] lane_byte [BeatBytes];

  logic beat;
  logic last_beat;
  logic word_full;

  // Take beats only with an instruction and room downstream
  assign r_ready_o = issue_valid_i && !rq_full_i;
  assign beat      = r_valid_i && r_ready_o;

  // First beat of an instruction starts from its full byte length
  assign remaining = (issue_bytes_q == '0) ? vinsn_bytes(issue_insn_i) : issue_bytes_q;
  assign last_beat = (remaining == vlen_t'(BeatBytes));
  assign word_full = (word_pnt_q == WordByteBits'(WordBytes - BeatBytes));

  always_comb begin
    for (int b = 0; b < BeatBytes; b++) begin
      lane_byte[b] = shuffle_byte(WordByteBits'(int'(word_pnt_q) + b), issue_insn_i.vsew);
    end
  end

  always_comb begin
    word_d        = word_q;
    word_pnt_d    = word_pnt_q;
    word_idx_d    = word_idx_q;
    issue_bytes_d = issue_bytes_q;
    push_o        = 1'b0;
    issue_done_o  = 1'b0;

    if (beat) begin
      // Scatter the beat bytes over the lanes
      for (int b = 0; b < BeatBytes; b++) begin
        word_d[lane_byte[b] / LaneBytes].wdata[8 * (lane_byte[b] % LaneBytes) +: 8] =
          r_data_i[8 * b +: 8];
        word_d[lane_byte[b] / LaneBytes].be[lane_byte[b] % LaneBytes] = 1'b1;
      end
      word_pnt_d    = word_pnt_q + WordByteBits'(BeatBytes);
      issue_bytes_d = remaining - vlen_t'(BeatBytes);

      // Last beat goes back to the queue as issue done
      issue_done_o = last_beat;

      // Word complete or instruction ending early
      if (word_full || last_beat) begin
        push_o     = 1'b1;
        word_pnt_d = '0;
        if (last_beat)
          word_idx_d = '0;
        else
          word_idx_d = word_idx_q + 1'b1;
      end
    end

    // Pushed word carries this beat plus the tag of the issue entry
    for (int l = 0; l < NrLanes; l++) begin
      push_word_o[l]      = word_d[l];
      push_word_o[l].id   = issue_insn_i.id;
      push_word_o[l].addr = word_addr(issue_insn_i.vd, word_idx_q);
    end

    // Start the next word from zero bytes and enables
    if (push_o)
      word_d = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_bytes_q <= '0;
      word_pnt_q    <= '0;
      word_idx_q    <= '0;
      word_q        <= '0;
    end else begin
      issue_bytes_q <= issue_bytes_d;
      word_pnt_q    <= word_pnt_d;
      word_idx_q    <= word_idx_d;
      word_q        <= word_d;
    end
  end

  // Each beat consumes a whole 8-byte slice of the instruction
  a_beat_whole: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat |-> (remaining != '0) && (remaining % vlen_t'(BeatBytes) == '0));

  // Issue entry stays put until its last beat
  a_issue_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat && !last_beat |=> issue_valid_i && $stable(issue_insn_i));

endmodule

`default_nettype wire

// ==== src/vldu_result_queue.sv ====
`default_nettype none

module vldu_result_queue import vldu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Push side
  input  logic                        push_i,
  input  lane_payload_t [NrLanes-1:0] push_word_i,
  output logic                        full_o,
  // Lane write ports
  output logic          [NrLanes-1:0] req_o,
  output vid_t          [NrLanes-1:0] id_o,
  output vaddr_t        [NrLanes-1:0] addr_o,
  output elen_t         [NrLanes-1:0] wdata_o,
  output strb_t         [NrLanes-1:0] be_o,
  input  logic          [NrLanes-1:0] gnt_i,
  // Head fully granted
  output logic                        word_retired_o
);

  ////////////////////
  // Storage
  ////////////////////

  lane_payload_t [ResultQueueDepth-1:0][NrLanes-1:0] mem_q;

  // Per-lane pending bits of each entry
  logic [ResultQueueDepth-1:0][NrLanes-1:0] valid_q, valid_d;

  logic [RqPtrBits-1:0] wr_pnt_q, wr_pnt_d;
  logic [RqPtrBits-1:0] rd_pnt_q, rd_pnt_d;
  logic [RqCntBits-1:0] cnt_q, cnt_d;

  assign full_o = (cnt_q == RqCntBits'(ResultQueueDepth));

  // Head entry drives every lane
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      req_o[l]   = valid_q[rd_pnt_q][l];
      id_o[l]    = mem_q[rd_pnt_q][l].id;
      addr_o[l]  = mem_q[rd_pnt_q][l].addr;
      wdata_o[l] = mem_q[rd_pnt_q][l].wdata;
      be_o[l]    = mem_q[rd_pnt_q][l].be;
    end
  end

  always_comb begin
    valid_d        = valid_q;
    wr_pnt_d       = wr_pnt_q;
    rd_pnt_d       = rd_pnt_q;
    cnt_d          = cnt_q;
    word_retired_o = 1'b0;

    // A grant clears its lane bit at the head
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~gnt_i;

    // Last outstanding lane granted
    if (cnt_q != '0 && valid_d[rd_pnt_q] == '0) begin
      word_retired_o = 1'b1;
      rd_pnt_d       = rd_pnt_q + 1'b1;
      cnt_d          = cnt_d - 1'b1;
    end

    // New word requests every lane
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
      wr_pnt_d          = wr_pnt_q + 1'b1;
      cnt_d             = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_pnt_q <= wr_pnt_d;
      rd_pnt_q <= rd_pnt_d;
      cnt_q    <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i)
      mem_q[wr_pnt_q] <= push_word_i;
  end

  // A waiting request keeps its payload until granted
  for (genvar l = 0; l < NrLanes; l++) begin : gen_req_chk
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_o[l] && !gnt_i[l] |=> req_o[l] && $stable(id_o[l]) && $stable(addr_o[l])
                                && $stable(wdata_o[l]) && $stable(be_o[l]));
  end

endmodule

`default_nettype wire

// ==== src/vldu_top.sv ====
`default_nettype none

module vldu_top import vldu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Load instructions from the sequencer
  input  logic                 insn_valid_i,
  input  vid_t                 insn_id_i,
  input  vreg_t                insn_vd_i,
  input  vew_e                 insn_vsew_i,
  input  vlen_t                insn_vl_i,
  output logic                 insn_ready_o,
  // Memory read beats
  input  logic                 r_valid_i,
  input  elen_t                r_data_i,
  output logic                 r_ready_o,
  // Lane writes
  output logic   [NrLanes-1:0] ldu_req_o,
  output vid_t   [NrLanes-1:0] ldu_id_o,
  output vaddr_t [NrLanes-1:0] ldu_addr_o,
  output elen_t  [NrLanes-1:0] ldu_wdata_o,
  output strb_t  [NrLanes-1:0] ldu_be_o,
  input  logic   [NrLanes-1:0] ldu_gnt_i,
  // Completion
  output logic   [NrVInsn-1:0] vinsn_done_o,
  output logic                 load_complete_o
);

  vinsn_t                      acc_insn;
  vinsn_t                      issue_insn;
  logic                        issue_valid;
  logic                        issue_done;
  logic                        push;
  logic                        rq_full;
  logic                        word_retired;
  lane_payload_t [NrLanes-1:0] push_word;

  // Instruction fields into one struct
  assign acc_insn = '{id: insn_id_i, vd: insn_vd_i, vsew: insn_vsew_i, vl: insn_vl_i};

  ////////////////////
  // Submodules
  ////////////////////

  vldu_insn_queue i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .acc_valid_i    (insn_valid_i),
    .acc_insn_i     (acc_insn),
    .acc_ready_o    (insn_ready_o),
    .issue_valid_o  (issue_valid),
    .issue_insn_o   (issue_insn),
    .issue_done_i   (issue_done),
    .word_retired_i (word_retired),
    .vinsn_done_o   (vinsn_done_o),
    .load_complete_o(load_complete_o)
  );

  vldu_beat_packer i_beat_packer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_valid_i(issue_valid),
    .issue_insn_i (issue_insn),
    .issue_done_o (issue_done),
    .r_valid_i    (r_valid_i),
    .r_data_i     (r_data_i),
    .r_ready_o    (r_ready_o),
    .push_o       (push),
    .push_word_o  (push_word),
    .rq_full_i    (rq_full)
  );

  vldu_result_queue i_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (push),
    .push_word_i   (push_word),
    .full_o        (rq_full),
    .req_o         (ldu_req_o),
    .id_o          (ldu_id_o),
    .addr_o        (ldu_addr_o),
    .wdata_o       (ldu_wdata_o),
    .be_o          (ldu_be_o),
    .gnt_i         (ldu_gnt_i),
    .word_retired_o(word_retired)
  );

endmodule

`default_nettype wire

// ==== test/tb_vldu.sv ====
`default_nettype none

module tb_vldu import vldu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////
  // Test length
  ////////////////////

  localparam int NrTests = 40;
  // Up to 32 beats and 8 words of 16 stall cycles per instruction, twice over
  localparam int TimeoutCycles = NrTests * (32 + 8 * 16) * 2;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                 clk_i;
  logic                 rst_ni;
  logic                 insn_valid_i;
  vid_t                 insn_id_i;
  vreg_t                insn_vd_i;
  vew_e                 insn_vsew_i;
  vlen_t                insn_vl_i;
  logic                 insn_ready_o;
  logic                 r_valid_i;
  elen_t                r_data_i;
  logic                 r_ready_o;
  logic   [NrLanes-1:0] ldu_req_o;
  vid_t   [NrLanes-1:0] ldu_id_o;
  vaddr_t [NrLanes-1:0] ldu_addr_o;
  elen_t  [NrLanes-1:0] ldu_wdata_o;
  strb_t  [NrLanes-1:0] ldu_be_o;
  logic   [NrLanes-1:0] ldu_gnt_i;
  logic   [NrVInsn-1:0] vinsn_done_o;
  logic                 load_complete_o;

  vldu_top DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_valid_i   (insn_valid_i),
    .insn_id_i      (insn_id_i),
    .insn_vd_i      (insn_vd_i),
    .insn_vsew_i    (insn_vsew_i),
    .insn_vl_i      (insn_vl_i),
    .insn_ready_o   (insn_ready_o),
    .r_valid_i      (r_valid_i),
    .r_data_i       (r_data_i),
    .r_ready_o      (r_ready_o),
    .ldu_req_o      (ldu_req_o),
    .ldu_id_o       (ldu_id_o),
    .ldu_addr_o     (ldu_addr_o),
    .ldu_wdata_o    (ldu_wdata_o),
    .ldu_be_o       (ldu_be_o),
    .ldu_gnt_i      (ldu_gnt_i),
    .vinsn_done_o   (vinsn_done_o),
    .load_complete_o(load_complete_o)
  );

  // 20 ns clock period
  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  ////////////////////
  // Model state
  ////////////////////

  // Accepted instructions still receiving beats
  vinsn_t        iss_q [$];
  // IDs expected on vinsn_done_o, in acceptance order
  vid_t          done_q [$];
  // One queue of expected words per lane
  lane_payload_t exp_q [NrLanes][$];

  logic [NrVInsn-1:0] tb_running;
  int                 pending;

  // Word under assembly in the model
  logic [7:0] wbuf [WordBytes];
  int         wcnt;
  int         beat_pos;
  int         widx;

  // Instruction currently offered
  vinsn_t offer;
  logic   offer_active;

  int n_offered;
  int n_done;
  int cycle_cnt;

  ////////////////////
  // Failure handling
  ////////////////////

  task automatic abort_run(input string why);
    $display("CHECKS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    abort_run($sformatf("wrong value on %s", name));
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_payload(input int lane, input lane_payload_t got,
                               input lane_payload_t exp);
    if (got.id !== exp.id)
      report_mismatch($sformatf("ldu_id_o[%0d]", lane), got.id, exp.id);
    if (got.addr !== exp.addr)
      report_mismatch($sformatf("ldu_addr_o[%0d]", lane), got.addr, exp.addr);
    if (got.wdata !== exp.wdata)
      report_mismatch($sformatf("ldu_wdata_o[%0d]", lane), got.wdata, exp.wdata);
    if (got.be !== exp.be)
      report_mismatch($sformatf("ldu_be_o[%0d]", lane), got.be, exp.be);
  endtask

  task automatic check_done(input vid_t exp_id);
    logic [NrVInsn-1:0] onehot;
    onehot = '0;
    onehot[exp_id] = 1'b1;
    if (vinsn_done_o !== onehot)
      report_mismatch("vinsn_done_o", vinsn_done_o, onehot);
    if (load_complete_o !== 1'b1)
      report_mismatch("load_complete_o", load_complete_o, 1'b1);
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp)
      report_mismatch("insn_ready_o", got, exp);
  endtask

  ////////////////////
  // Model helpers
  ////////////////////

  // Mostly a free ID
  // Any ID now and then to probe the refusal of running ones
  function automatic vid_t pick_id();
    vid_t free_ids [$];
    for (int i = 0; i < NrVInsn; i++) begin
      if (!tb_running[i])
        free_ids.push_back(vid_t'(i));
    end
    if (free_ids.size() == 0 || $urandom % 4 == 0)
      return vid_t'($urandom % NrVInsn);
    return free_ids[$urandom % free_ids.size()];
  endfunction

  // Words of an instruction not yet written to every lane
  function automatic int words_left(input vid_t id);
    int cnt;
    cnt = 0;
    foreach (iss_q[i]) begin
      if (iss_q[i].id == id)
        cnt++;
    end
    for (int l = 0; l < NrLanes; l++) begin
      for (int i = 0; i < exp_q[l].size(); i++) begin
        if (exp_q[l][i].id == id)
          cnt++;
      end
    end
    return cnt;
  endfunction

  // Spread the model word over the lanes
  // Byte b is byte b mod ew of element b div ew
  // Element e sits in lane e mod 4
  task automatic push_expected(input vinsn_t insn, input int nbytes, input int w);
    lane_payload_t word [NrLanes];
    int ew;
    int e;
    int lane;
    int off;
    ew = 1 << int'(insn.vsew);
    for (int l = 0; l < NrLanes; l++) begin
      word[l]      = '0;
      word[l].id   = insn.id;
      word[l].addr = vaddr_t'(int'(insn.vd) * RegWords + w);
    end
    for (int b = 0; b < nbytes; b++) begin
      e    = b / ew;
      lane = e % NrLanes;
      off  = (e / NrLanes) * ew + b % ew;
      word[lane].wdata[8 * off +: 8] = wbuf[b];
      word[lane].be[off]             = 1'b1;
    end
    for (int l = 0; l < NrLanes; l++)
      exp_q[l].push_back(word[l]);
  endtask

  task automatic take_beat();
    vinsn_t cur;
    int     total;
    if (iss_q.size() == 0)
      abort_run("read beat taken while no instruction was pending");
    cur   = iss_q[0];
    total = int'(cur.vl) << int'(cur.vsew);
    for (int b = 0; b < 8; b++)
      wbuf[wcnt + b] = r_data_i[8 * b +: 8];
    wcnt     += 8;
    beat_pos += 8;
    // Full word or short last word of the instruction
    if (wcnt == WordBytes || beat_pos == total) begin
      push_expected(cur, wcnt, widx);
      widx++;
      wcnt = 0;
    end
    if (beat_pos == total) begin
      void'(iss_q.pop_front());
      beat_pos = 0;
      widx     = 0;
    end
  endtask

  ////////////////////
  // Per-cycle work
  ////////////////////

  task automatic drive_inputs();
    int nbytes;
    if (!offer_active && n_offered < NrTests && $urandom % 4 != 0) begin
      nbytes       = 8 * (1 + $urandom % 32);
      offer.id     = pick_id();
      offer.vd     = vreg_t'($urandom);
      offer.vsew   = vew_e'($urandom % 4);
      offer.vl     = vlen_t'(nbytes >> int'(offer.vsew));
      offer_active = 1'b1;
      n_offered++;
    end
    insn_valid_i = offer_active;
    insn_id_i    = offer.id;
    insn_vd_i    = offer.vd;
    insn_vsew_i  = offer.vsew;
    insn_vl_i    = offer.vl;
    r_valid_i    = ($urandom % 4 != 0);
    r_data_i     = {$urandom, $urandom};
    ldu_gnt_i    = NrLanes'($urandom);
  endtask

  // Outputs are stable at the falling edge
  // Handshakes seen here fire at the next rise
  task automatic sample_outputs();
    vid_t          id;
    lane_payload_t got;
    // Done pulse from the previous rising edge
    if (vinsn_done_o != '0 || load_complete_o) begin
      if (done_q.size() == 0)
        abort_run("done pulse with no instruction outstanding");
      id = done_q.pop_front();
      check_done(id);
      if (words_left(id) != 0)
        abort_run("instruction reported done before all its words were written");
      tb_running[id] = 1'b0;
      pending--;
      n_done++;
    end
    check_ready(insn_ready_o, pending < InsnQueueDepth && !tb_running[insn_id_i]);
    // Lane writes granted at the next edge
    for (int l = 0; l < NrLanes; l++) begin
      if (ldu_req_o[l] && ldu_gnt_i[l]) begin
        if (exp_q[l].size() == 0)
          abort_run($sformatf("lane %0d wrote a word that was never loaded", l));
        got.id    = ldu_id_o[l];
        got.addr  = ldu_addr_o[l];
        got.wdata = ldu_wdata_o[l];
        got.be    = ldu_be_o[l];
        check_payload(l, got, exp_q[l].pop_front());
      end
    end
    // Beats go first so a beat is never charged to a fresh instruction
    if (r_valid_i && r_ready_o)
      take_beat();
    if (insn_valid_i && insn_ready_o) begin
      iss_q.push_back(offer);
      done_q.push_back(offer.id);
      tb_running[offer.id] = 1'b1;
      pending++;
      offer_active = 1'b0;
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(32'h6a3710c7));
    rst_ni       = 1'b0;
    insn_valid_i = 1'b0;
    insn_id_i    = '0;
    insn_vd_i    = '0;
    insn_vsew_i  = EW8;
    insn_vl_i    = '0;
    r_valid_i    = 1'b0;
    r_data_i     = '0;
    ldu_gnt_i    = '0;
    tb_running   = '0;
    pending      = 0;
    wcnt         = 0;
    beat_pos     = 0;
    widx         = 0;
    offer        = '0;
    offer_active = 1'b0;
    n_offered    = 0;
    n_done       = 0;
    cycle_cnt    = 0;

    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Idle state right after reset
    @(negedge clk_i);
    if (!insn_ready_o || r_ready_o || ldu_req_o != '0 || vinsn_done_o != '0
        || load_complete_o)
      abort_run("outputs not in their idle state after reset");
    @(posedge clk_i);
    #2;

    while (n_done < NrTests) begin
      drive_inputs();
      @(negedge clk_i);
      sample_outputs();
      @(posedge clk_i);
      #2;
      cycle_cnt++;
      if (cycle_cnt > TimeoutCycles)
        abort_run($sformatf("timeout after %0d cycles with %0d of %0d instructions done",
                            cycle_cnt, n_done, NrTests));
    end

    // No stray word, beat intake or done pulse once the last instruction is done
    if (ldu_req_o != '0 || r_ready_o || !insn_ready_o || vinsn_done_o != '0
        || load_complete_o) begin
      abort_run("outputs not back to idle after the last instruction was done");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vldu.f ====
src/vldu_pkg.sv
src/vldu_insn_queue.sv
src/vldu_beat_packer.sv
src/vldu_result_queue.sv
src/vldu_top.sv
test/tb_vldu.sv
